// ==== design/osc_num_pkg.sv ====
package osc_num_pkg;

  // signed 2.16 fixed point, 2 integer bits incl. sign
  localparam int FIX_W    = 18;
  localparam int FIX_FRAC = 16;

  typedef logic signed [FIX_W-1:0] fix_t;

  // spring constants
  // kcubic is carried for the register map only, the force sum ignores it
  typedef struct packed {
    fix_t k1;
    fix_t kmid;
    fix_t k2;
    fix_t kcubic;
  } osc_coef_t;

  // values loaded on restart
  typedef struct packed {
    fix_t x1;
    fix_t x2;
    fix_t v1;
    fix_t v2;
  } osc_init_t;

  // visible positions of both masses
  typedef struct packed {
    fix_t x1;
    fix_t x2;
  } osc_state_t;

  // 2.16 x 2.16 gives 4.32, keep the middle 18 bits
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic signed [2*FIX_W-1:0] prod;
    prod = a * b;
    return prod[FIX_W+FIX_FRAC-1:FIX_FRAC];
  endfunction

endpackage

// ==== design/trace_pkg.sv ====
package trace_pkg;

  localparam int COL_W = 10;  // up to 1023 columns
  localparam int ROW_W = 9;   // up to 511 rows

  typedef logic [COL_W-1:0] col_t;
  typedef logic [ROW_W-1:0] row_t;

  // plotter state, the value doubles as pixel colour
  typedef enum logic [1:0] {
    TRACE_IDLE = 2'd0,
    TRACE_2    = 2'd1,
    TRACE_1    = 2'd2
  } trace_sel_e;

  // one frame buffer write
  typedef struct packed {
    col_t       col;
    row_t       row;
    logic [1:0] colour;
  } pix_wr_t;

endpackage

// ==== design/euler_integrator.sv ====
`timescale 1ns/1ps

module euler_integrator #(
  parameter int unsigned DT_SHIFT = 9
) (
  input  logic               AnalogClock,
  input  logic               rst_n,
  input  logic               restart,
  input  logic               step,
  input  osc_num_pkg::fix_t  deriv,
  input  osc_num_pkg::fix_t  init_val,
  output osc_num_pkg::fix_t  value
);

  import osc_num_pkg::*;

  fix_t delta;

  // dt is a power of two, so the product is an arithmetic shift
  assign delta = deriv >>> DT_SHIFT;

  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n)
    begin
      value <= '0;
    end
    else if (restart)
    begin
      value <= init_val;        // restart wins over step
    end
    else if (step)
    begin
      value <= value + delta;   // wraps in 18 bits
    end
  end

endmodule

// ==== design/coupled_force.sv ====
`timescale 1ns/1ps

module coupled_force #(
  parameter osc_num_pkg::fix_t DAMPING = 18'sh00800
) (
  input  osc_num_pkg::osc_coef_t  coef,
  input  osc_num_pkg::osc_state_t state,
  input  osc_num_pkg::fix_t       v1,
  input  osc_num_pkg::fix_t       v2,
  output osc_num_pkg::fix_t       a1,
  output osc_num_pkg::fix_t       a2
);

  import osc_num_pkg::*;

  fix_t dx;          // stretch of the middle spring
  fix_t mid_term;    // shared coupling force
  fix_t k1_term;
  fix_t k2_term;
  fix_t damp1_term;
  fix_t damp2_term;

  // x2 - x1 wraps before the multiply
  assign dx = state.x2 - state.x1;

  // the middle spring pulls both masses with the same product
  assign mid_term = fix_mul(coef.kmid, dx);

  // outer springs, sign of k decides restoring direction
  assign k1_term = fix_mul(coef.k1, state.x1);
  assign k2_term = fix_mul(coef.k2, state.x2);

  // velocity damping, fixed gain
  assign damp1_term = fix_mul(DAMPING, v1);
  assign damp2_term = fix_mul(DAMPING, v2);

  // coef.kcubic does not enter the sums
  assign a1 = mid_term + k1_term + damp1_term;
  assign a2 = mid_term + k2_term + damp2_term;

endmodule

// ==== design/oscillator_core.sv ====
`timescale 1ns/1ps

module oscillator_core #(
  parameter int unsigned       STEP_DIV = 32,
  parameter int unsigned       DT_SHIFT = 9,
  parameter osc_num_pkg::fix_t DAMPING  = 18'sh00800
) (
  input  logic                    AnalogClock,
  input  logic                    rst_n,
  input  logic                    restart,
  input  osc_num_pkg::osc_coef_t  coef,
  input  osc_num_pkg::osc_init_t  init,
  output osc_num_pkg::osc_state_t state,
  output logic                    step
);

  import osc_num_pkg::*;

  localparam int unsigned CW = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

  logic [CW-1:0] div_cnt;
  fix_t          x1;
  fix_t          x2;
  fix_t          v1;
  fix_t          v2;
  fix_t          a1;
  fix_t          a2;

  // one step strobe every STEP_DIV clocks
  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n || restart)
    begin
      div_cnt <= '0;
      step    <= 1'b0;
    end
    else if (div_cnt == CW'(STEP_DIV - 1))
    begin
      div_cnt <= '0;
      step    <= 1'b1;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
      step    <= 1'b0;
    end
  end

  assign state = '{x1: x1, x2: x2};

  // accelerations from the values before the step
  coupled_force #(
    .DAMPING (DAMPING)
  ) i_force (
    .coef  (coef),
    .state (state),
    .v1    (v1),
    .v2    (v2),
    .a1    (a1),
    .a2    (a2)
  );

  // mass 1
  euler_integrator #(.DT_SHIFT(DT_SHIFT)) i_v1 (
    .AnalogClock (AnalogClock), .rst_n (rst_n), .restart (restart),
    .step (step), .deriv (a1), .init_val (init.v1), .value (v1)
  );

  euler_integrator #(.DT_SHIFT(DT_SHIFT)) i_x1 (
    .AnalogClock (AnalogClock), .rst_n (rst_n), .restart (restart),
    .step (step), .deriv (v1), .init_val (init.x1), .value (x1)
  );

  // mass 2 takes its own initial position
  euler_integrator #(.DT_SHIFT(DT_SHIFT)) i_v2 (
    .AnalogClock (AnalogClock), .rst_n (rst_n), .restart (restart),
    .step (step), .deriv (a2), .init_val (init.v2), .value (v2)
  );

  euler_integrator #(.DT_SHIFT(DT_SHIFT)) i_x2 (
    .AnalogClock (AnalogClock), .rst_n (rst_n), .restart (restart),
    .step (step), .deriv (v2), .init_val (init.x2), .value (x2)
  );

  // restart loads each mass from its own init value
  a_restart_loads_init : assert property (
    @(posedge AnalogClock) disable iff (!rst_n)
    restart |=> (x1 == $past(init.x1)) && (x2 == $past(init.x2))
  );

endmodule

// ==== design/trace_plotter.sv ====
`timescale 1ns/1ps

module trace_plotter #(
  parameter int unsigned PLOT_DECIM   = 16,
  parameter int unsigned SCREEN_WIDTH = 640,
  parameter int unsigned X1_ROW       = 120,
  parameter int unsigned X2_ROW       = 360
) (
  input  logic                    AnalogClock,
  input  logic                    rst_n,
  input  logic                    restart,
  input  logic                    step,
  input  osc_num_pkg::osc_state_t state,
  output trace_pkg::pix_wr_t      pix_wr,
  output logic                    pix_wr_valid
);

  import trace_pkg::*;

  localparam int unsigned DW = (PLOT_DECIM > 1) ? $clog2(PLOT_DECIM) : 1;

  logic [DW-1:0] dec_cnt;     // steps within one column
  col_t          col;         // next column to draw
  col_t          wr_col;      // column of the write in flight
  row_t          row1;
  row_t          row2;
  row_t          row1_next;
  row_t          row2_next;
  logic          armed;       // set by the first restart
  logic          plot;
  trace_sel_e    sel;

  // top 6 bits of the position, sign extended, around the trace baseline
  assign row1_next = {{3{state.x1[17]}}, state.x1[16:11]} + row_t'(X1_ROW);
  assign row2_next = {{3{state.x2[17]}}, state.x2[16:11]} + row_t'(X2_ROW);

  assign plot = armed && step && !restart && (dec_cnt == '0) && (col < SCREEN_WIDTH);

  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n)
    begin
      armed   <= 1'b0;
      col     <= '0;
      dec_cnt <= '0;
    end
    else if (restart)
    begin
      armed   <= 1'b1;
      col     <= '0;
      dec_cnt <= '0;
    end
    else
    begin
      if (step)
        dec_cnt <= (dec_cnt == DW'(PLOT_DECIM - 1)) ? '0 : dec_cnt + 1'b1;
      if (plot)
        col <= col + 1'b1;
    end
  end

  // snapshot for the two writes
  always_ff @(posedge AnalogClock)
  begin
    if (plot)
    begin
      wr_col <= col;
      row1   <= row1_next;
      row2   <= row2_next;
    end
  end

  // trace 2 first, then trace 1
  always_ff @(posedge AnalogClock)
  begin
    if (!rst_n)
      sel <= TRACE_IDLE;
    else
    begin
      case (sel)
        TRACE_IDLE: sel <= plot ? TRACE_2 : TRACE_IDLE;
        TRACE_2:    sel <= TRACE_1;
        default:    sel <= plot ? TRACE_2 : TRACE_IDLE;
      endcase
    end
  end

  assign pix_wr_valid = (sel != TRACE_IDLE);
  assign pix_wr = '{
    col:    wr_col,
    row:    (sel == TRACE_2) ? row2 : row1,
    colour: 2'(sel)              // enum value is the colour code
  };

  // each column is exactly two writes
  a_write_burst_len : assert property (
    @(posedge AnalogClock) disable iff (!rst_n)
    pix_wr_valid [*2] |=> !pix_wr_valid
  );

endmodule

// ==== design/eulersillator_top.sv ====
`timescale 1ns/1ps

module eulersillator_top #(
  parameter int unsigned       STEP_DIV     = 32,
  parameter int unsigned       DT_SHIFT     = 9,
  parameter osc_num_pkg::fix_t DAMPING      = 18'sh00800,  // 0.03125
  parameter int unsigned       PLOT_DECIM   = 16,
  parameter int unsigned       SCREEN_WIDTH = 640,
  parameter int unsigned       X1_ROW       = 120,
  parameter int unsigned       X2_ROW       = 360
) (
  input  logic                    AnalogClock,
  input  logic                    rst_n,
  input  logic                    restart,
  input  osc_num_pkg::osc_coef_t  coef,
  input  osc_num_pkg::osc_init_t  init,
  output osc_num_pkg::osc_state_t state,
  output trace_pkg::pix_wr_t      pix_wr,
  output logic                    pix_wr_valid
);

  logic step;   // Euler step strobe from the core

  oscillator_core #(
    .STEP_DIV (STEP_DIV),
    .DT_SHIFT (DT_SHIFT),
    .DAMPING  (DAMPING)
  ) i_core (
    .AnalogClock (AnalogClock),
    .rst_n       (rst_n),
    .restart     (restart),
    .coef        (coef),
    .init        (init),
    .state       (state),
    .step        (step)
  );

  trace_plotter #(
    .PLOT_DECIM   (PLOT_DECIM),
    .SCREEN_WIDTH (SCREEN_WIDTH),
    .X1_ROW       (X1_ROW),
    .X2_ROW       (X2_ROW)
  ) i_plotter (
    .AnalogClock  (AnalogClock),
    .rst_n        (rst_n),
    .restart      (restart),
    .step         (step),
    .state        (state),
    .pix_wr       (pix_wr),
    .pix_wr_valid (pix_wr_valid)
  );

endmodule

// ==== tb/tb_eulersillator.sv ====
`timescale 1ns/1ps

module tb_eulersillator;

  import osc_num_pkg::*;
  import trace_pkg::*;

  localparam int   STEP_DIV     = 8;
  localparam int   DT_SHIFT     = 9;
  localparam fix_t DAMPING      = 18'sh00800;  // 0.03125
  localparam int   PLOT_DECIM   = 2;
  localparam int   SCREEN_WIDTH = 48;
  localparam int   X1_ROW       = 120;
  localparam int   X2_ROW       = 360;
  localparam int   TOTAL_STEPS  = 20 + 10 + 200 + 8;
  localparam int   WATCHDOG_CYC = TOTAL_STEPS * STEP_DIV + 600;

  logic       AnalogClock;
  logic       rst_n;
  logic       restart;
  osc_coef_t  coef;
  osc_init_t  init;
  osc_state_t state;
  pix_wr_t    pix_wr;
  logic       pix_wr_valid;

  // reference model state
  fix_t m_x1;
  fix_t m_x2;
  fix_t m_v1;
  fix_t m_v2;
  int   m_col;
  int   m_dec;
  bit   pending;      // a column write pair is due
  col_t p_col;
  row_t p_row1;
  row_t p_row2;

  eulersillator_top #(
    .STEP_DIV     (STEP_DIV),
    .DT_SHIFT     (DT_SHIFT),
    .DAMPING      (DAMPING),
    .PLOT_DECIM   (PLOT_DECIM),
    .SCREEN_WIDTH (SCREEN_WIDTH),
    .X1_ROW       (X1_ROW),
    .X2_ROW       (X2_ROW)
  ) i_dut (
    .AnalogClock  (AnalogClock),
    .rst_n        (rst_n),
    .restart      (restart),
    .coef         (coef),
    .init         (init),
    .state        (state),
    .pix_wr       (pix_wr),
    .pix_wr_valid (pix_wr_valid)
  );

  always #2 AnalogClock = ~AnalogClock;  // 4 ns period

  // 2.16 product from the full 36 bits
  function automatic fix_t mul_fix(input fix_t a, input fix_t b);
    logic signed [35:0] p;
    p = a * b;
    return p[33:16];
  endfunction

  function automatic row_t pos_to_row(input fix_t x, input int offset);
    fix_t coarse;
    coarse = x >>> 11;  // one row per 1/32
    return coarse[8:0] + row_t'(offset);
  endfunction

  // signed value in -lim .. lim
  function automatic fix_t rnd_fix(input int lim);
    int r;
    r = int'($urandom_range(2 * lim, 0)) - lim;
    return fix_t'(r);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one Euler step on the old values
  task automatic model_step();
    fix_t dx;
    fix_t a1;
    fix_t a2;
    dx = m_x2 - m_x1;
    a1 = mul_fix(coef.kmid, dx) + mul_fix(coef.k1, m_x1) + mul_fix(DAMPING, m_v1);
    a2 = mul_fix(coef.kmid, dx) + mul_fix(coef.k2, m_x2) + mul_fix(DAMPING, m_v2);
    m_x1 = m_x1 + (m_v1 >>> DT_SHIFT);
    m_x2 = m_x2 + (m_v2 >>> DT_SHIFT);
    m_v1 = m_v1 + (a1 >>> DT_SHIFT);
    m_v2 = m_v2 + (a2 >>> DT_SHIFT);
  endtask

  task automatic do_restart();
    @(posedge AnalogClock);
    #1;
    restart = 1'b1;
    @(posedge AnalogClock);
    #1;
    restart = 1'b0;
    check_val("state.x1", state.x1, init.x1);
    check_val("state.x2", state.x2, init.x2);
    m_x1    = init.x1;
    m_x2    = init.x2;
    m_v1    = init.v1;
    m_v2    = init.v2;
    m_col   = 0;
    m_dec   = 0;
    pending = 1'b0;
  endtask

  // c counts clocks since the last step strobe
  task automatic check_cycle(input int c, input bit step_exp);
    check_val("step", i_dut.step, step_exp);
    check_val("state.x1", state.x1, m_x1);
    check_val("state.x2", state.x2, m_x2);
    if (pending && c == 1)
    begin
      check_val("pix_wr_valid", pix_wr_valid, 1'b1);
      check_val("pix_wr.col", pix_wr.col, p_col);
      check_val("pix_wr.row", pix_wr.row, p_row2);  // trace 2 goes first
      check_val("pix_wr.colour", pix_wr.colour, 2'd1);
    end
    else if (pending && c == 2)
    begin
      check_val("pix_wr_valid", pix_wr_valid, 1'b1);
      check_val("pix_wr.col", pix_wr.col, p_col);
      check_val("pix_wr.row", pix_wr.row, p_row1);
      check_val("pix_wr.colour", pix_wr.colour, 2'd2);
      pending = 1'b0;
    end
    else
      check_val("pix_wr_valid", pix_wr_valid, 1'b0);
    if (step_exp)
    begin
      if (m_dec == 0 && m_col < SCREEN_WIDTH)
      begin
        pending = 1'b1;
        p_col   = col_t'(m_col);
        p_row1  = pos_to_row(m_x1, X1_ROW);
        p_row2  = pos_to_row(m_x2, X2_ROW);
        m_col++;
      end
      m_dec = (m_dec + 1) % PLOT_DECIM;
      model_step();
    end
  endtask

  task automatic run_steps(input int n);
    repeat (n)
    begin
      for (int c = 1; c <= STEP_DIV; c++)
      begin
        @(posedge AnalogClock);
        #1;
        check_cycle(c, c == STEP_DIV);
      end
    end
    for (int c = 1; c <= 3; c++)
    begin
      @(posedge AnalogClock);
      #1;
      check_cycle(c, 1'b0);  // drain the last write pair
    end
  endtask

  task automatic test_idle_after_reset();
    repeat (50)
    begin
      @(posedge AnalogClock);
      #1;
      check_val("state.x1", state.x1, '0);
      check_val("state.x2", state.x2, '0);
      check_val("pix_wr_valid", pix_wr_valid, 1'b0);
    end
  endtask

  task automatic test_restart_load();
    init.x1 = rnd_fix(32768);
    init.x2 = init.x1 + 18'sh04000;  // never equal to x1
    init.v1 = rnd_fix(4096);
    init.v2 = rnd_fix(4096);
    do_restart();
    init.x1 = rnd_fix(32768);
    init.x2 = init.x1 - 18'sh02000;
    do_restart();
  endtask

  task automatic test_zero_coef();
    fix_t x1_exp;
    coef    = '0;
    init.x1 = 18'sh04000;
    init.x2 = 18'sh3e000;
    init.v1 = '0;
    init.v2 = '0;
    do_restart();
    run_steps(20);
    check_val("state.x1", state.x1, init.x1);
    check_val("state.x2", state.x2, init.x2);
    init.v1 = 18'sh01000;  // damping term shifts out to zero
    do_restart();
    run_steps(10);
    x1_exp = init.x1 + fix_t'(10 * (init.v1 >>> DT_SHIFT));
    check_val("state.x1", state.x1, x1_exp);
  endtask

  task automatic test_random_run();
    coef.k1     = rnd_fix(16384);
    coef.kmid   = rnd_fix(16384);
    coef.k2     = rnd_fix(16384);
    coef.kcubic = rnd_fix(65535);  // must have no effect
    init.x1     = rnd_fix(32768);
    init.x2     = rnd_fix(32768);
    init.v1     = rnd_fix(8192);
    init.v2     = rnd_fix(8192);
    do_restart();
    run_steps(200);
  endtask

  // columns start over from 0
  task automatic test_replot();
    init.x1 = rnd_fix(32768);
    init.x2 = rnd_fix(32768);
    do_restart();
    run_steps(8);
  endtask

  initial
  begin
    void'($urandom(32'h43f8_2d87));
    AnalogClock = 1'b0;
    rst_n       = 1'b0;
    restart     = 1'b0;
    coef        = '0;
    init        = '0;
    repeat (16) @(posedge AnalogClock);
    #1;
    rst_n = 1'b1;
    test_idle_after_reset();
    test_restart_load();
    test_zero_coef();
    test_random_run();
    test_replot();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYC * 4);
    $display("timeout: the run took longer than the tests need");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== tb.f ====
design/osc_num_pkg.sv
design/trace_pkg.sv
design/euler_integrator.sv
design/coupled_force.sv
design/oscillator_core.sv
design/trace_plotter.sv
design/eulersillator_top.sv
tb/tb_eulersillator.sv

// ==== Bender.yml ====
package:
  name: eulersillator

sources:
  - design/osc_num_pkg.sv
  - design/trace_pkg.sv
  - design/euler_integrator.sv
  - design/coupled_force.sv
  - design/oscillator_core.sv
  - design/trace_plotter.sv
  - design/eulersillator_top.sv
  - target: test
    files:
      - tb/tb_eulersillator.sv
